//--- hw/cpu_consts.svh
`ifndef CPU_CONSTS_SVH
`define CPU_CONSTS_SVH

// memory port widths
`define CPU_ADDR_W 32
`define CPU_DATA_W 32

// register file lives in memory starting at base_addr
`define CPU_REG_COUNT 16

// opcode occupies the command word from this bit up to the msb
`define CPU_OP_LSB 28

`endif

//--- hw/cpu_pkg.sv
`include "cpu_consts.svh"

package cpu_pkg;

  // one operand slot of the command word
  // flags 01 post-increment and 10 post-decrement
  // 00 and 11 leave the register unchanged
  typedef struct packed {
    logic [$clog2(`CPU_REG_COUNT)-1:0] reg_num;
    logic                              is_ptr;
    logic [1:0]                        flags;
  } operand_field_t;

  // unknown codes fall back to mov
  typedef enum logic [`CPU_DATA_W-`CPU_OP_LSB-1:0] {
    op_mov,
    op_add,
    op_sub,
    op_and,
    op_or,
    op_xor
  } alu_op_e;

  typedef struct packed {
    alu_op_e        op;
    operand_field_t cond;
    operand_field_t dst;
    operand_field_t src0;
    operand_field_t src1;
  } command_t;

  typedef struct packed {
    logic [`CPU_ADDR_W-1:0] addr;
    logic [`CPU_DATA_W-1:0] wdata;
    logic                   read;
    logic                   write;
  } mem_req_t;

  typedef struct packed {
    logic [`CPU_DATA_W-1:0] cond;
    logic [`CPU_DATA_W-1:0] src1;
    logic [`CPU_DATA_W-1:0] src0;
  } operands_t;

  // numeric order is the order the steps run in
  typedef enum logic [3:0] {
    ph_fetch,
    ph_cond,
    ph_cond_ptr,
    ph_src1,
    ph_src1_ptr,
    ph_src0,
    ph_src0_ptr,
    ph_write_dst,
    ph_wb_src1,
    ph_wb_src0,
    ph_wb_cond
  } phase_e;

endpackage

//--- hw/operand_sequencer.sv
`timescale 1ns/1ps
`include "cpu_consts.svh"

module operand_sequencer (
  input  logic                   clk,
  input  logic                   rst,
  input  logic                   start,
  input  logic [`CPU_DATA_W-1:0] rdata,
  input  cpu_pkg::operands_t     operands,
  input  logic                   step_done,
  output cpu_pkg::phase_e        phase,
  output logic                   go,
  output logic                   exec,
  output cpu_pkg::command_t      cmd,
  output logic                   busy,
  output logic                   done,
  output logic                   taken
);

  typedef enum logic [1:0] {
    st_idle,
    st_step,
    st_exec
  } state_e;

  state_e                 state_q;
  logic [`CPU_DATA_W-1:0] rdata_q;
  logic                   cond_nz;
  logic                   next_valid;
  cpu_pkg::phase_e        next_phase;
  logic                   reads_done;

  // whether a given step runs for this command
  function automatic logic phase_enabled(
    input cpu_pkg::phase_e   p,
    input cpu_pkg::command_t c,
    input logic              nz
  );
    case (p)
      cpu_pkg::ph_cond,
      cpu_pkg::ph_src1,
      cpu_pkg::ph_src0:      phase_enabled = 1'b1;
      cpu_pkg::ph_cond_ptr:  phase_enabled = c.cond.is_ptr;
      cpu_pkg::ph_src1_ptr:  phase_enabled = c.src1.is_ptr;
      cpu_pkg::ph_src0_ptr:  phase_enabled = c.src0.is_ptr;
      cpu_pkg::ph_write_dst: phase_enabled = nz;
      // odd parity of the flags means 01 or 10
      cpu_pkg::ph_wb_src1:   phase_enabled = ^c.src1.flags;
      cpu_pkg::ph_wb_src0:   phase_enabled = ^c.src0.flags;
      cpu_pkg::ph_wb_cond:   phase_enabled = ^c.cond.flags;
      default:               phase_enabled = 1'b0;
    endcase
  endfunction

  assign cond_nz = |operands.cond;

  // lowest enabled step above the current one
  always_comb begin
    next_valid = 1'b0;
    next_phase = phase;
    for (int i = int'(cpu_pkg::ph_wb_cond); i > int'(cpu_pkg::ph_fetch); i--) begin
      if (i > int'(phase) && phase_enabled(cpu_pkg::phase_e'(i), cmd, cond_nz)) begin
        next_valid = 1'b1;
        next_phase = cpu_pkg::phase_e'(i);
      end
    end
  end

  assign reads_done = (phase != cpu_pkg::ph_fetch) && (phase <= cpu_pkg::ph_src0_ptr) &&
                      !(next_valid && next_phase <= cpu_pkg::ph_src0_ptr);

  // step_done trails read_dn by one cycle, so the delayed copy holds the word
  always_ff @(posedge clk) begin
    rdata_q <= rdata;
    if (state_q == st_step && step_done && phase == cpu_pkg::ph_fetch) begin
      cmd <= cpu_pkg::command_t'(rdata_q);
    end
  end

  always_ff @(posedge clk) begin
    if (rst) begin
      state_q <= st_idle;
      phase   <= cpu_pkg::ph_fetch;
      go      <= 1'b0;
      exec    <= 1'b0;
      busy    <= 1'b0;
      done    <= 1'b0;
      taken   <= 1'b0;
    end else begin
      go    <= 1'b0;
      exec  <= 1'b0;
      done  <= 1'b0;
      taken <= 1'b0;
      case (state_q)
        st_idle: begin
          if (start) begin
            phase   <= cpu_pkg::ph_fetch;
            go      <= 1'b1;
            busy    <= 1'b1;
            state_q <= st_step;
          end
        end
        st_step: begin
          if (step_done) begin
            if (phase == cpu_pkg::ph_fetch) begin
              phase <= cpu_pkg::ph_cond;
              go    <= 1'b1;
            end else begin
              exec <= reads_done;
              if (!next_valid) begin
                done    <= 1'b1;
                taken   <= cond_nz;
                busy    <= 1'b0;
                state_q <= st_idle;
              end else if (next_phase == cpu_pkg::ph_write_dst) begin
                // one spare cycle so the ALU result settles
                phase   <= next_phase;
                state_q <= st_exec;
              end else begin
                phase <= next_phase;
                go    <= 1'b1;
              end
            end
          end
        end
        st_exec: begin
          go      <= 1'b1;
          state_q <= st_step;
        end
        default: state_q <= st_idle;
      endcase
    end
  end

endmodule

//--- hw/mem_manager.sv
`timescale 1ns/1ps
`include "cpu_consts.svh"

module mem_manager (
  input  logic                   clk,
  input  logic                   rst,
  input  cpu_pkg::phase_e        phase,
  input  logic                   go,
  input  logic [`CPU_ADDR_W-1:0] ip,
  input  logic [`CPU_ADDR_W-1:0] base_addr,
  input  cpu_pkg::command_t      cmd,
  input  logic [`CPU_DATA_W-1:0] result,
  input  logic [`CPU_DATA_W-1:0] rdata,
  input  logic                   read_dn,
  input  logic                   write_dn,
  output cpu_pkg::mem_req_t      req,
  output logic                   step_done,
  output cpu_pkg::operands_t     operands
);

  typedef enum logic [1:0] {
    slot_cond,
    slot_src1,
    slot_src0
  } slot_e;

  slot_e                   sel_slot;
  cpu_pkg::operand_field_t sel_field;
  logic [`CPU_DATA_W-1:0]  sel_val;
  logic [`CPU_ADDR_W-1:0]  sel_adr;
  logic [`CPU_ADDR_W-1:0]  reg_addr;
  logic [`CPU_DATA_W-1:0]  wb_base;
  logic [`CPU_DATA_W-1:0]  wb_value;

  logic [`CPU_ADDR_W-1:0]  next_addr;
  logic [`CPU_DATA_W-1:0]  next_wdata;
  logic                    next_read;
  logic                    next_write;

  // address each operand was read from (the pointer for indirect fields)
  logic [`CPU_ADDR_W-1:0]  cond_adr_q;
  logic [`CPU_ADDR_W-1:0]  src1_adr_q;
  logic [`CPU_ADDR_W-1:0]  src0_adr_q;

  logic [`CPU_ADDR_W-1:0]  req_addr_q;
  logic [`CPU_DATA_W-1:0]  req_wdata_q;
  logic                    read_q;
  logic                    write_q;
  logic                    wait_read_q;
  logic                    wait_write_q;

  // which operand slot the current phase works on
  always_comb begin
    case (phase)
      cpu_pkg::ph_src1, cpu_pkg::ph_src1_ptr, cpu_pkg::ph_wb_src1: begin
        sel_slot  = slot_src1;
        sel_field = cmd.src1;
        sel_val   = operands.src1;
        sel_adr   = src1_adr_q;
      end
      cpu_pkg::ph_src0, cpu_pkg::ph_src0_ptr, cpu_pkg::ph_wb_src0: begin
        sel_slot  = slot_src0;
        sel_field = cmd.src0;
        sel_val   = operands.src0;
        sel_adr   = src0_adr_q;
      end
      default: begin
        sel_slot  = slot_cond;
        sel_field = cmd.cond;
        sel_val   = operands.cond;
        sel_adr   = cond_adr_q;
      end
    endcase
  end

  assign reg_addr = base_addr + `CPU_ADDR_W'(sel_field.reg_num);

  // pointer fields step the pointer, direct fields step the value
  assign wb_base  = sel_field.is_ptr ? sel_adr : sel_val;
  assign wb_value = (sel_field.flags == 2'b01) ? wb_base + 1'b1 : wb_base - 1'b1;

  always_comb begin
    next_addr  = reg_addr;
    next_wdata = wb_value;
    next_read  = 1'b0;
    next_write = 1'b0;
    case (phase)
      cpu_pkg::ph_fetch: begin
        next_addr = ip;
        next_read = 1'b1;
      end
      cpu_pkg::ph_cond, cpu_pkg::ph_src1, cpu_pkg::ph_src0: begin
        next_read = 1'b1;
      end
      cpu_pkg::ph_cond_ptr, cpu_pkg::ph_src1_ptr, cpu_pkg::ph_src0_ptr: begin
        next_addr = sel_val;
        next_read = 1'b1;
      end
      cpu_pkg::ph_write_dst: begin
        next_addr  = base_addr + `CPU_ADDR_W'(cmd.dst.reg_num);
        next_wdata = result;
        next_write = 1'b1;
      end
      cpu_pkg::ph_wb_src1, cpu_pkg::ph_wb_src0, cpu_pkg::ph_wb_cond: begin
        next_write = 1'b1;
      end
      default: begin
        next_read  = 1'b0;
        next_write = 1'b0;
      end
    endcase
  end

  always_ff @(posedge clk) begin
    if (rst) begin
      read_q       <= 1'b0;
      write_q      <= 1'b0;
      wait_read_q  <= 1'b0;
      wait_write_q <= 1'b0;
      step_done    <= 1'b0;
    end else begin
      read_q    <= go & next_read;
      write_q   <= go & next_write;
      step_done <= (wait_read_q & read_dn) | (wait_write_q & write_dn);
      if (go) begin
        wait_read_q  <= next_read;
        wait_write_q <= next_write;
      end else begin
        if (read_dn) begin
          wait_read_q <= 1'b0;
        end
        if (write_dn) begin
          wait_write_q <= 1'b0;
        end
      end
    end
  end

  always_ff @(posedge clk) begin
    if (go) begin
      req_addr_q  <= next_addr;
      req_wdata_q <= next_wdata;
      if (next_read && phase != cpu_pkg::ph_fetch) begin
        case (sel_slot)
          slot_src1: src1_adr_q <= next_addr;
          slot_src0: src0_adr_q <= next_addr;
          default:   cond_adr_q <= next_addr;
        endcase
      end
    end
    // the fetched word goes to the sequencer, not into an operand slot
    if (wait_read_q && read_dn && phase != cpu_pkg::ph_fetch) begin
      case (sel_slot)
        slot_src1: operands.src1 <= rdata;
        slot_src0: operands.src0 <= rdata;
        default:   operands.cond <= rdata;
      endcase
    end
  end

  assign req = '{addr: req_addr_q, wdata: req_wdata_q, read: read_q, write: write_q};

endmodule

//--- hw/exec_unit.sv
`timescale 1ns/1ps
`include "cpu_consts.svh"

module exec_unit (
  input  logic                   clk,
  input  logic                   rst,
  input  logic                   exec,
  input  cpu_pkg::alu_op_e       op,
  input  logic [1:0]             dst_flags,
  input  cpu_pkg::operands_t     operands,
  output logic [`CPU_DATA_W-1:0] result
);

  logic [`CPU_DATA_W-1:0] alu_out;
  logic [`CPU_DATA_W-1:0] mod_out;

  always_comb begin
    case (op)
      cpu_pkg::op_add: alu_out = operands.src0 + operands.src1;
      cpu_pkg::op_sub: alu_out = operands.src0 - operands.src1;
      cpu_pkg::op_and: alu_out = operands.src0 & operands.src1;
      cpu_pkg::op_or:  alu_out = operands.src0 | operands.src1;
      cpu_pkg::op_xor: alu_out = operands.src0 ^ operands.src1;
      // mov and any unused code
      default:         alu_out = operands.src0;
    endcase
  end

  // dst modifier applies to the result itself
  always_comb begin
    case (dst_flags)
      2'b01:   mod_out = alu_out + 1'b1;
      2'b10:   mod_out = alu_out - 1'b1;
      default: mod_out = alu_out;
    endcase
  end

  always_ff @(posedge clk) begin
    if (rst) begin
      result <= '0;
    end else if (exec) begin
      result <= mod_out;
    end
  end

endmodule

//--- hw/operand_core.sv
`timescale 1ns/1ps
`include "cpu_consts.svh"

module operand_core (
  input  logic                   clk,
  input  logic                   rst,
  input  logic                   start,
  input  logic [`CPU_ADDR_W-1:0] ip,
  input  logic [`CPU_ADDR_W-1:0] base_addr,
  input  logic [`CPU_DATA_W-1:0] rdata,
  input  logic                   read_dn,
  input  logic                   write_dn,
  output cpu_pkg::mem_req_t      req,
  output logic                   busy,
  output logic                   done,
  output logic                   taken
);

  cpu_pkg::phase_e        phase;
  cpu_pkg::command_t      cmd;
  cpu_pkg::operands_t     operands;
  logic                   go;
  logic                   exec;
  logic                   step_done;
  logic [`CPU_DATA_W-1:0] result;

  operand_sequencer operand_sequencer_i (
    .clk       (clk),
    .rst       (rst),
    .start     (start),
    .rdata     (rdata),
    .operands  (operands),
    .step_done (step_done),
    .phase     (phase),
    .go        (go),
    .exec      (exec),
    .cmd       (cmd),
    .busy      (busy),
    .done      (done),
    .taken     (taken)
  );

  mem_manager mem_manager_i (
    .clk       (clk),
    .rst       (rst),
    .phase     (phase),
    .go        (go),
    .ip        (ip),
    .base_addr (base_addr),
    .cmd       (cmd),
    .result    (result),
    .rdata     (rdata),
    .read_dn   (read_dn),
    .write_dn  (write_dn),
    .req       (req),
    .step_done (step_done),
    .operands  (operands)
  );

  // dst pointer bit is reserved and only its flags reach the ALU
  exec_unit exec_unit_i (
    .clk       (clk),
    .rst       (rst),
    .exec      (exec),
    .op        (cmd.op),
    .dst_flags (cmd.dst.flags),
    .operands  (operands),
    .result    (result)
  );

endmodule

//--- tests/operand_core_tb.sv
`timescale 1ns/1ps
`include "cpu_consts.svh"

module operand_core_tb;

  localparam int done_timeout = 200;
  localparam int idle_window  = 8;

  logic                   clk;
  logic                   rst;
  logic                   start;
  logic [`CPU_ADDR_W-1:0] ip;
  logic [`CPU_ADDR_W-1:0] base_addr;
  logic [`CPU_DATA_W-1:0] rdata;
  logic                   read_dn;
  logic                   write_dn;
  cpu_pkg::mem_req_t      req;
  logic                   busy;
  logic                   done;
  logic                   taken;

  // behavioral memory and per-case bookkeeping
  logic [`CPU_DATA_W-1:0] mem [logic [`CPU_ADDR_W-1:0]];
  cpu_pkg::mem_req_t      exp_writes[$];
  logic [`CPU_ADDR_W-1:0] case_ip;
  logic [`CPU_ADDR_W-1:0] case_base;
  int                     write_count;
  int                     done_count;
  integer                 seed;

  operand_core operand_core_i (
    .clk       (clk),
    .rst       (rst),
    .start     (start),
    .ip        (ip),
    .base_addr (base_addr),
    .rdata     (rdata),
    .read_dn   (read_dn),
    .write_dn  (write_dn),
    .req       (req),
    .busy      (busy),
    .done      (done),
    .taken     (taken)
  );

  initial begin
    clk = 1'b0;
    forever #2 clk = ~clk;
  end

  task automatic report_failure(input string msg);
    $display("%s", msg);
    $display("Testbench failed");
    $fatal(1);
  endtask

  task automatic check_req(input cpu_pkg::mem_req_t act, input cpu_pkg::mem_req_t exp);
    if (act !== exp) begin
      report_failure({
        $sformatf("Fail at %0t: req got addr=%h wdata=%h read=%b write=%b",
                  $time, act.addr, act.wdata, act.read, act.write),
        $sformatf(" expected addr=%h wdata=%h read=%b write=%b",
                  exp.addr, exp.wdata, exp.read, exp.write)});
    end
  endtask

  task automatic check_taken(input logic act, input logic exp);
    if (act !== exp) begin
      report_failure($sformatf("Fail at %0t: taken got %b expected %b", $time, act, exp));
    end
  endtask

  // words never preloaded read back as the inverted address
  function automatic logic [`CPU_DATA_W-1:0] read_word(input logic [`CPU_ADDR_W-1:0] addr);
    if (mem.exists(addr)) begin
      read_word = mem[addr];
    end else begin
      read_word = ~addr;
    end
  endfunction

  // memory answers one access at a time after 1 to 4 cycles
  initial begin : memory_model
    int                delay_left;
    logic              pending;
    cpu_pkg::mem_req_t held;
    seed       = 32'h704;
    pending    = 1'b0;
    delay_left = 0;
    rdata      <= '0;
    read_dn    <= 1'b0;
    write_dn   <= 1'b0;
    forever begin
      @(posedge clk);
      read_dn  <= 1'b0;
      write_dn <= 1'b0;
      if (!rst && done) begin
        done_count++;
      end
      if (!rst && (req.read || req.write)) begin
        if (pending || (req.read && req.write)) begin
          report_failure("memory got a new request while another was still outstanding");
        end
        held       = req;
        pending    = 1'b1;
        delay_left = 1 + ($random(seed) & 3);
        if (req.write) begin
          if (exp_writes.size() == 0) begin
            report_failure($sformatf("unexpected write to address %h with data %h at %0t",
                                     req.addr, req.wdata, $time));
          end
          check_req(req, exp_writes.pop_front());
          mem[req.addr] = req.wdata;
          write_count++;
        end
      end
      if (pending) begin
        delay_left--;
        if (delay_left == 0) begin
          pending = 1'b0;
          if (held.read) begin
            rdata   <= read_word(held.addr);
            read_dn <= 1'b1;
          end else begin
            write_dn <= 1'b1;
          end
        end
      end
    end
  end

  // one command per case plus a second start while busy
  task automatic run_case(input logic exp_taken);
    int   cycles;
    int   n_writes;
    logic seen_done;
    n_writes    = exp_writes.size();
    write_count = 0;
    done_count  = 0;
    seen_done   = 1'b0;
    cycles      = 0;
    ip        <= case_ip;
    base_addr <= case_base;
    start     <= 1'b1;
    while (!seen_done) begin
      @(posedge clk);
      cycles++;
      start <= (cycles == 3);
      if (cycles == 3 && !busy) begin
        report_failure("busy is not high while the command is running");
      end
      if (done) begin
        check_taken(taken, exp_taken);
        seen_done = 1'b1;
      end else if (cycles > done_timeout) begin
        report_failure("timed out waiting for done");
      end
    end
    start <= 1'b0;
    for (int i = 0; i < idle_window; i++) begin
      @(posedge clk);
      if (busy) begin
        report_failure("busy rose again after done, the extra start was not ignored");
      end
    end
    if (done_count != 1) begin
      report_failure($sformatf("Fail at %0t: done count got %0d expected 1", $time, done_count));
    end
    if (write_count != n_writes || exp_writes.size() != 0) begin
      report_failure($sformatf("Fail at %0t: write count got %0d expected %0d",
                               $time, write_count, n_writes));
    end
  endtask

  initial begin : run_tests
    int                     fd;
    int                     code;
    int                     n_cases;
    string                  line;
    logic [`CPU_DATA_W-1:0] a;
    logic [`CPU_DATA_W-1:0] b;
    cpu_pkg::mem_req_t      wr;
    n_cases   = 0;
    rst       <= 1'b1;
    start     <= 1'b0;
    ip        <= '0;
    base_addr <= '0;
    repeat (10) @(posedge clk);
    rst <= 1'b0;
    @(posedge clk);
    fd = $fopen("tests/operand_core_tests.txt", "r");
    if (fd == 0) begin
      report_failure("cannot open tests/operand_core_tests.txt");
    end
    while (!$feof(fd)) begin
      line = "";
      code = $fgets(line, fd);
      if (code != 0 && line.len() > 1 && line[0] != "#") begin
        a    = '0;
        b    = '0;
        code = $sscanf(line.substr(1, line.len() - 1), "%h %h", a, b);
        case (line[0])
          "M": mem[a] = b;
          "S": begin
            case_ip   = a;
            case_base = b;
            exp_writes.delete();
          end
          "W": begin
            wr = '{addr: a, wdata: b, read: 1'b0, write: 1'b1};
            exp_writes.push_back(wr);
          end
          "E": begin
            run_case(a[0]);
            n_cases++;
          end
          default: report_failure($sformatf("unknown line in test file: %s", line));
        endcase
      end
    end
    $fclose(fd);
    if (n_cases == 0) begin
      report_failure("test file held no cases");
    end else begin
      $display("Testbench passed");
      $finish;
    end
  end

endmodule

//--- tests/operand_core_tests.txt
# M addr data: preload word | S ip base_addr: begin case
# W addr data: expected write in order | E taken: run case (all hex)
M 100 00000000
M 101 00000001
M 103 000000f6
M 104 0000003c
M 105 00000200
M 106 00000020
M 107 00000007
M 108 00000080
M 200 00000011
# mov add sub and, cond r1, dst r2, src0 r3, src1 r4
M 40 01040c20
S 40 100
W 102 000000f6
E 1
M 41 11040c20
S 41 100
W 102 00000132
E 1
M 42 21040c20
S 42 100
W 102 000000ba
E 1
M 43 31040c20
S 43 100
W 102 00000034
E 1
# or with dst increment, xor with dst decrement
M 44 41044c20
S 44 100
W 102 000000ff
E 1
M 45 51048c20
S 45 100
W 102 000000c9
E 1
# zero cond r0, src1 r6 dec, src0 r7 inc, cond inc
M 46 10321cb2
S 46 100
W 106 0000001f
W 107 00000008
W 100 00000001
E 0
# src0 r5 is a pointer to 200 with increment, cond flags 11
M 47 117416a0
S 47 100
W 10a 0000004d
W 105 00000201
E 1
# sub, src1 r6 inc, src0 r7 dec, cond r8 dec
M 48 28441d31
S 48 100
W 102 ffffffe9
W 106 00000020
W 107 00000007
W 108 0000007f
E 1

//--- flist.f
+incdir+hw
hw/cpu_pkg.sv
hw/operand_sequencer.sv
hw/mem_manager.sv
hw/exec_unit.sv
hw/operand_core.sv
tests/operand_core_tb.sv

//--- Makefile
TOOL       = verilator
TOP        = operand_core_tb
FLIST      = flist.f
LINT_FLAGS = --lint-only --timing
SIM_FLAGS  = --binary --timing -Wno-fatal
BUILD_DIR  = obj_dir

.PHONY: all lint sim clean

all: sim

lint:
	$(TOOL) $(LINT_FLAGS) --top-module $(TOP) -f $(FLIST)

# a $fatal in the run gives a nonzero exit status
sim:
	$(TOOL) $(SIM_FLAGS) --top-module $(TOP) -f $(FLIST) --Mdir $(BUILD_DIR)
	./$(BUILD_DIR)/V$(TOP)

clean:
	rm -rf $(BUILD_DIR)
